/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= pipe_ctrl_tb
FILELIST  ?= pipe_ctrl.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/pipe_ctrl_checker.sv */
// compares commit records and hazard hints with the queued expectations
// records are queued and sampled on the falling edge
`timescale 1ns/10ps

module pipe_ctrl_checker
(
    input  logic                    clk_i,
    input  pipe_ctrl_pkg::commit_t  commit_i,
    input  logic                    squash_i,
    input  logic                    load_e1_i,
    input  logic                    store_e1_i,
    input  logic                    mul_e1_i,
    input  logic                    branch_e1_i,
    input  pipe_ctrl_pkg::reg_idx_t rd_e1_i,
    input  logic                    load_e2_i,
    input  logic                    mul_e2_i,
    input  pipe_ctrl_pkg::reg_idx_t rd_e2_i,
    input  pipe_ctrl_pkg::word_t    result_e2_i,
    input  logic                    exp_valid_i,
    input  pipe_ctrl_pkg::commit_t  exp_i,
    input  logic [3:0]              exp_hints_i,   // load, store, mul, branch
    input  pipe_ctrl_pkg::reg_idx_t exp_hint_rd_i,
    output int                      error_count_o,
    output int                      pending_o
);
    import pipe_ctrl_pkg::*;

    commit_t    exp_q [$];
    logic [8:0] hint_q [$];     // {load, store, mul, branch, rd}
    logic [8:0] e1_hint;
    logic       e1_due = 1'b0;
    logic       squash_prev = 1'b0;
    logic       load_e2_prev = 1'b0;
    logic       mul_e2_prev = 1'b0;
    reg_idx_t   rd_e2_prev = '0;
    word_t      result_e2_prev = '0;
    int         errors = 0;

    initial
    begin
        error_count_o = 0;
        pending_o     = 0;
    end

    task automatic check_field(input string name, input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("** Error %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    always @(negedge clk_i)
    begin
        commit_t    want;
        logic [8:0] want_hint;
        // E1 took the newest entry on the last rising edge
        if (e1_due)
        begin
            check_field("load_e1_o", 32'(load_e1_i), 32'(e1_hint[8]));
            check_field("store_e1_o", 32'(store_e1_i), 32'(e1_hint[7]));
            check_field("mul_e1_o", 32'(mul_e1_i), 32'(e1_hint[6]));
            check_field("branch_e1_o", 32'(branch_e1_i), 32'(e1_hint[5]));
            check_field("rd_e1_o", 32'(rd_e1_i), 32'(e1_hint[4:0]));
            e1_due = 1'b0;
        end
        if (exp_valid_i)
        begin
            exp_q.push_back(exp_i);
            hint_q.push_back({exp_hints_i, exp_hint_rd_i});
            e1_hint = {exp_hints_i, exp_hint_rd_i};
            e1_due  = 1'b1;
        end
        if (commit_i.valid || commit_i.exception != EXCP_NONE)
        begin
            if (exp_q.size() == 0)
            begin
                $display("commit at pc %h arrived with nothing expected", commit_i.pc);
                errors++;
            end
            else
            begin
                want      = exp_q.pop_front();
                want_hint = hint_q.pop_front();
                check_field("commit_o.valid", 32'(commit_i.valid), 32'(want.valid));
                check_field("commit_o.csr", 32'(commit_i.csr), 32'(want.csr));
                check_field("commit_o.rd", 32'(commit_i.rd), 32'(want.rd));
                check_field("commit_o.result", commit_i.result, want.result);
                check_field("commit_o.pc", commit_i.pc, want.pc);
                check_field("commit_o.opcode", commit_i.opcode, want.opcode);
                check_field("commit_o.operand_ra", commit_i.operand_ra, want.operand_ra);
                check_field("commit_o.operand_rb", commit_i.operand_rb, want.operand_rb);
                check_field("commit_o.exception", 32'(commit_i.exception),
                            32'(want.exception));
                // E2 as it was one cycle before the commit
                check_field("load_e2_o", 32'(load_e2_prev), 32'(want_hint[8]));
                check_field("mul_e2_o", 32'(mul_e2_prev), 32'(want_hint[6]));
                check_field("rd_e2_o", 32'(rd_e2_prev), 32'(want_hint[4:0]));
                check_field("result_e2_o", result_e2_prev, want.result);
                check_field("squash_e1_e2_o", 32'(squash_prev),
                            32'(want.exception != EXCP_NONE));
                check_field("squash_e1_e2_o", 32'(squash_i),
                            32'(want.exception != EXCP_NONE));   // held one more cycle
            end
        end
        squash_prev    = squash_i;
        load_e2_prev   = load_e2_i;
        mul_e2_prev    = mul_e2_i;
        rd_e2_prev     = rd_e2_i;
        result_e2_prev = result_e2_i;
        error_count_o  = errors;
        pending_o      = exp_q.size();
    end

endmodule

/* bench/pipe_ctrl_tb.sv */
// testbench for pipe_ctrl_top, one instruction in flight at a time
// stall_o is looped back into issue_stall_i as the issue logic would do
`timescale 1ns/10ps

module pipe_ctrl_tb;
    import pipe_ctrl_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 8 + 20;

    typedef struct packed {
        issue_req_t  req;
        e1_result_t  e1r;
        e2_result_t  e2r;
        div_result_t dr;
        logic [1:0]  delay;   // cycles until div/mem completes
        logic        follow;  // issue a second op right behind, must never retire
        logic [3:0]  hints;   // load, store, mul, branch seen in E1 and E2
        reg_idx_t    hint_rd; // rd on the hazard ports
        commit_t     exp;
    } entry_t;

    logic        clk_i;
    logic        rst_i;
    issue_req_t  issue_req;
    e1_result_t  e1_result;
    e2_result_t  e2_result;
    div_result_t div_result;
    logic        issue_stall;
    logic        squash_e1_e2;
    logic        squash_wb;
    commit_t     commit;
    logic        stall;
    logic        squash_out;
    logic        load_e1;
    logic        store_e1;
    logic        mul_e1;
    logic        branch_e1;
    reg_idx_t    rd_e1;
    logic        load_e2;
    logic        mul_e2;
    reg_idx_t    rd_e2;
    word_t       result_e2;
    logic        exp_valid;
    commit_t     exp_rec;
    logic [3:0]  exp_hints;
    reg_idx_t    exp_hint_rd;
    int          chk_errors;
    int          chk_pending;

    entry_t      table_q [NUM_ENTRIES];
    int          seed = 69470;
    int          cycles = 0;
    int          stim_errors = 0;

    assign issue_stall = stall;   // environment feedback

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    pipe_ctrl_top u_dut
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_req_i    (issue_req),
        .e1_result_i    (e1_result),
        .e2_result_i    (e2_result),
        .div_result_i   (div_result),
        .issue_stall_i  (issue_stall),
        .squash_e1_e2_i (squash_e1_e2),
        .squash_wb_i    (squash_wb),
        .commit_o       (commit),
        .stall_o        (stall),
        .squash_e1_e2_o (squash_out),
        .load_e1_o      (load_e1),
        .store_e1_o     (store_e1),
        .mul_e1_o       (mul_e1),
        .branch_e1_o    (branch_e1),
        .rd_e1_o        (rd_e1),
        .load_e2_o      (load_e2),
        .mul_e2_o       (mul_e2),
        .rd_e2_o        (rd_e2),
        .result_e2_o    (result_e2)
    );

    pipe_ctrl_checker u_chk
    (
        .clk_i         (clk_i),
        .commit_i      (commit),
        .squash_i      (squash_out),
        .load_e1_i     (load_e1),
        .store_e1_i    (store_e1),
        .mul_e1_i      (mul_e1),
        .branch_e1_i   (branch_e1),
        .rd_e1_i       (rd_e1),
        .load_e2_i     (load_e2),
        .mul_e2_i      (mul_e2),
        .rd_e2_i       (rd_e2),
        .result_e2_i   (result_e2),
        .exp_valid_i   (exp_valid),
        .exp_i         (exp_rec),
        .exp_hints_i   (exp_hints),
        .exp_hint_rd_i (exp_hint_rd),
        .error_count_o (chk_errors),
        .pending_o     (chk_pending)
    );

    //----------------------------------------------------------------------
    // stimulus table
    //----------------------------------------------------------------------
    task automatic build_table();
        entry_t   e;
        word_t    r;
        word_t    pc;
        reg_idx_t rd;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            e  = '0;
            r  = $random(seed);
            pc = 32'h0000_1000 + 32'(i) * 32'h40;
            rd = 5'(i + 1);
            e.req.valid          = 1'b1;
            e.req.accept         = 1'b1;
            e.req.rd_valid       = 1'b1;
            e.req.pc             = pc;
            e.req.opcode         = {r[31:12], rd, 7'h33};
            e.req.operand_ra     = $random(seed);
            e.req.operand_rb     = $random(seed);
            e.e1r.alu_result     = $random(seed);
            e.e1r.csr_value      = $random(seed);
            e.e2r.mem_result     = $random(seed);
            e.e2r.mul_result     = $random(seed);
            e.dr.result          = $random(seed);
            e.hint_rd            = rd;
            e.exp.valid          = 1'b1;
            e.exp.rd             = rd;
            e.exp.result         = e.e1r.alu_result;
            e.exp.pc             = pc;
            e.exp.opcode         = e.req.opcode;
            e.exp.operand_ra     = e.req.operand_ra;
            e.exp.operand_rb     = e.req.operand_rb;
            case (i)
                1:
                begin
                    e.req.div    = 1'b1;
                    e.delay      = 2'd3;
                    e.exp.result = e.dr.result;
                end
                2:
                begin
                    e.req.csr    = 1'b1;
                    e.exp.csr    = 1'b1;
                    e.exp.result = e.e1r.csr_value;
                end
                3:
                begin
                    e.req.lsu    = 1'b1;
                    e.delay      = 2'd3;
                    e.hints      = 4'b1000;
                    e.exp.result = e.e2r.mem_result;
                end
                4:
                begin
                    e.req.mul    = 1'b1;
                    e.hints      = 4'b0010;
                    e.exp.result = e.e2r.mul_result;
                end
                5:
                begin
                    // taken branch to a halfword address
                    e.req.branch        = 1'b1;
                    e.req.rd_valid      = 1'b0;
                    e.req.branch_taken  = 1'b1;
                    e.req.branch_target = pc + 32'h22;
                    e.follow            = 1'b1;
                    e.hints             = 4'b0001;
                    e.hint_rd           = '0;
                    e.exp.valid         = 1'b0;
                    e.exp.rd            = '0;
                    e.exp.exception     = 6'h10;
                end
                6:
                begin
                    e.req.take_interrupt = 1'b1;
                    e.req.csr            = 1'b1;
                    e.hint_rd            = '0;
                    e.exp.rd             = '0;
                    e.exp.exception      = 6'h20;
                end
                7:
                begin
                    e.req.lsu             = 1'b1;
                    e.e2r.mem_exception   = 6'h15;
                    e.follow              = 1'b1;
                    e.hints               = 4'b1000;
                    e.exp.valid           = 1'b0;
                    e.exp.rd              = '0;
                    e.exp.exception       = 6'h15;
                    e.exp.result          = e.e2r.mem_result;
                end
                default:
                begin
                end
            endcase
            table_q[i] = e;
        end
    endtask

    task automatic run_entry(input entry_t e);
        issue_req_t  fol;
        e2_result_t  e2r;
        div_result_t dr;
        int          guard;
        fol              = '0;
        fol.valid        = 1'b1;
        fol.accept       = 1'b1;
        fol.rd_valid     = 1'b1;
        fol.pc           = e.req.pc + 32'd4;
        fol.opcode       = e.req.opcode ^ 32'h0000_0f80;
        fol.operand_ra   = $random(seed);
        fol.operand_rb   = $random(seed);
        e2r              = e.e2r;
        e2r.mem_complete = !(e.req.lsu && e.delay != 2'd0);
        dr               = e.dr;
        dr.complete      = !(e.req.div && e.delay != 2'd0);

        @(posedge clk_i);
        issue_req   <= e.req;
        e1_result   <= e.e1r;
        e2_result   <= e2r;
        div_result  <= dr;
        exp_valid   <= 1'b1;
        exp_rec     <= e.exp;
        exp_hints   <= e.hints;
        exp_hint_rd <= e.hint_rd;
        @(posedge clk_i);
        exp_valid  <= 1'b0;
        if (e.follow)
        begin
            issue_req <= fol;
            @(posedge clk_i);
        end
        issue_req <= '0;

        // unit still busy, the pipe must hold
        // a load only stalls once it has reached E2
        for (int k = 0; k < int'(e.delay); k++)
        begin
            @(negedge clk_i);
            if ((e.req.div || (e.req.lsu && k > 0)) && stall !== 1'b1)
            begin
                $display("** Error stall_o: got %h expected %h", stall, 1'b1);
                stim_errors++;
            end
            @(posedge clk_i);
        end
        e2_result.mem_complete <= 1'b1;
        div_result.complete    <= 1'b1;

        guard = 0;
        @(negedge clk_i);
        while (!(commit.valid || commit.exception != EXCP_NONE) && guard < 12)
        begin
            @(negedge clk_i);
            guard++;
        end
        if (guard >= 12)
        begin
            $display("no commit seen for the instruction at pc %h", e.req.pc);
            stim_errors++;
        end
        @(posedge clk_i);   // let the squash window close
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial
    begin
        rst_i        = 1'b1;
        issue_req    = '0;
        e1_result    = '0;
        e2_result    = '0;
        div_result   = '0;
        squash_e1_e2 = 1'b0;
        squash_wb    = 1'b0;
        exp_valid    = 1'b0;
        exp_rec      = '0;
        exp_hints    = '0;
        exp_hint_rd  = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(table_q[i]);
        repeat (3) @(posedge clk_i);
        if (chk_pending != 0)
        begin
            $display("%0d expected commits never appeared", chk_pending);
            stim_errors++;
        end
        $display("errors: checker %0d, stimulus %0d", chk_errors, stim_errors);
        if (chk_errors == 0 && stim_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

/* design/pipe_commit_stage.sv */
// WB register and commit record
// outputs read as idle while the pipe is stalled
`timescale 1ns/10ps

module pipe_commit_stage
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  pipe_ctrl_pkg::stage_t     e2_i,
    input  pipe_ctrl_pkg::e2_result_t e2_result_i,
    input  logic                     issue_stall_i,
    input  logic                     squash_wb_i,
    output pipe_ctrl_pkg::commit_t    commit_o
);
    import pipe_ctrl_pkg::*;

    logic        valid_q;
    ctrl_flags_t ctrl_q;
    excp_t       excp_q;
    word_t       result_q;
    word_t       pc_q;
    word_t       opcode_q;
    word_t       ra_q;
    word_t       rb_q;

    logic        valid_adv_w;
    logic        mem_fault_w;
    logic        commit_valid_w;
    reg_idx_t    rd_w;

    assign valid_adv_w = e2_i.valid & ~issue_stall_i;

    // load/store faults never retire
    always_comb
    begin
        case (e2_i.exception)
            EXCP_MISALIGNED_LOAD,
            EXCP_FAULT_LOAD,
            EXCP_MISALIGNED_STORE,
            EXCP_FAULT_STORE,
            EXCP_PAGE_FAULT_LOAD,
            EXCP_PAGE_FAULT_STORE: mem_fault_w = 1'b1;
            default:               mem_fault_w = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
            excp_q  <= EXCP_NONE;
        end
        else if (!issue_stall_i)
        begin
            if (squash_wb_i)
            begin
                valid_q <= 1'b0;
                ctrl_q  <= '0;
                excp_q  <= EXCP_NONE;
            end
            else
            begin
                valid_q         <= e2_i.valid & ~mem_fault_w;
                ctrl_q          <= e2_i.ctrl;
                ctrl_q.rd_valid <= e2_i.ctrl.rd_valid & ~(|e2_i.exception); // no rf write
                excp_q          <= e2_i.exception;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!issue_stall_i && !squash_wb_i)
        begin
            pc_q     <= e2_i.pc;
            opcode_q <= e2_i.opcode;
            ra_q     <= e2_i.operand_ra;
            rb_q     <= e2_i.operand_rb;
            if (valid_adv_w && (e2_i.ctrl.load || e2_i.ctrl.store))
                result_q <= e2_result_i.mem_result;
            else if (valid_adv_w && e2_i.ctrl.mul)
                result_q <= e2_result_i.mul_result;
            else
                result_q <= e2_i.result;
        end
    end

    assign commit_valid_w = valid_q & ~issue_stall_i;
    assign rd_w = (commit_valid_w && ctrl_q.rd_valid) ? opcode_q[RD_LSB +: 5] : '0;

    assign commit_o = '{valid: commit_valid_w, csr: ctrl_q.csr & ~issue_stall_i, rd: rd_w,
                        result: result_q, pc: pc_q, opcode: opcode_q, operand_ra: ra_q,
                        operand_rb: rb_q, exception: excp_q};

endmodule

/* design/pipe_ctrl_pkg.sv */
// shared types for the scalar E1/E2/WB control path
// exception codes follow the RISC-V mcause values, bit 5 marks an interrupt
package pipe_ctrl_pkg;

    typedef logic [31:0] word_t;    // data word or address
    typedef logic [4:0]  reg_idx_t; // integer register index
    typedef logic [5:0]  excp_t;    // exception code

    //----------------------------------------------------------------------
    // exception codes
    //----------------------------------------------------------------------
    localparam excp_t EXCP_NONE             = 6'h00;
    localparam excp_t EXCP_MISALIGNED_FETCH = 6'h10;
    localparam excp_t EXCP_MISALIGNED_LOAD  = 6'h14;
    localparam excp_t EXCP_FAULT_LOAD       = 6'h15;
    localparam excp_t EXCP_MISALIGNED_STORE = 6'h16;
    localparam excp_t EXCP_FAULT_STORE      = 6'h17;
    localparam excp_t EXCP_PAGE_FAULT_LOAD  = 6'h1D;
    localparam excp_t EXCP_PAGE_FAULT_STORE = 6'h1F;
    localparam excp_t EXCP_INTERRUPT        = 6'h20;

    localparam int unsigned RD_LSB  = 7;     // rd field is opcode[11:7]
    localparam word_t       PC_STEP = 32'd4; // no compressed instructions

    //----------------------------------------------------------------------
    // bundles
    //----------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        logic  accept;
        logic  lsu;
        logic  csr;
        logic  div;
        logic  mul;
        logic  branch;
        logic  rd_valid;
        excp_t exception;
        logic  take_interrupt;
        logic  branch_taken;
        word_t branch_target;
        word_t pc;
        word_t opcode;
        word_t operand_ra;
        word_t operand_rb;
    } issue_req_t;

    typedef struct packed {
        logic alu;
        logic load;
        logic store;
        logic csr;
        logic div;
        logic mul;
        logic branch;
        logic rd_valid;
        logic intr;     // interrupt taken on this slot
        logic complete;
    } ctrl_flags_t;

    typedef struct packed {
        logic        valid;
        ctrl_flags_t ctrl;
        word_t       pc;
        word_t       npc;
        word_t       opcode;
        word_t       operand_ra;
        word_t       operand_rb;
        excp_t       exception;
        word_t       result;
    } stage_t;

    typedef struct packed {
        word_t alu_result;
        word_t csr_value;
        excp_t csr_exception;
    } e1_result_t;

    typedef struct packed {
        logic  mem_complete;
        word_t mem_result;
        excp_t mem_exception;
        word_t mul_result;
    } e2_result_t;

    typedef struct packed {
        logic  complete;
        word_t result;
    } div_result_t;

    typedef struct packed {
        logic     valid;
        logic     csr;
        reg_idx_t rd;
        word_t    result;
        word_t    pc;
        word_t    opcode;
        word_t    operand_ra;
        word_t    operand_rb;
        excp_t    exception;
    } commit_t;

endpackage

/* design/pipe_ctrl_top.sv */
// three stage E1/E2/WB control, scalar path only
// stall_o is expected to be fed back into issue_stall_i
`timescale 1ns/10ps

module pipe_ctrl_top
#(
    parameter bit SUPPORT_LOAD_BYPASS = 1'b1,
    parameter bit SUPPORT_MUL_BYPASS  = 1'b1
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  pipe_ctrl_pkg::issue_req_t  issue_req_i,
    input  pipe_ctrl_pkg::e1_result_t  e1_result_i,
    input  pipe_ctrl_pkg::e2_result_t  e2_result_i,
    input  pipe_ctrl_pkg::div_result_t div_result_i,
    input  logic                      issue_stall_i,
    input  logic                      squash_e1_e2_i,
    input  logic                      squash_wb_i,
    output pipe_ctrl_pkg::commit_t     commit_o,
    output logic                      stall_o,
    output logic                      squash_e1_e2_o,
    output logic                      load_e1_o,
    output logic                      store_e1_o,
    output logic                      mul_e1_o,
    output logic                      branch_e1_o,
    output pipe_ctrl_pkg::reg_idx_t    rd_e1_o,
    output logic                      load_e2_o,
    output logic                      mul_e2_o,
    output pipe_ctrl_pkg::reg_idx_t    rd_e2_o,
    output pipe_ctrl_pkg::word_t       result_e2_o
);
    import pipe_ctrl_pkg::*;

    stage_t e1_w;
    stage_t e2_w;
    logic   e2_wr_w;

    pipe_issue_stage u_issue
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_req_i    (issue_req_i),
        .issue_stall_i  (issue_stall_i),
        .squash_e1_e2_i (squash_e1_e2_i),
        .squash_local_i (squash_e1_e2_o),
        .e1_o           (e1_w)
    );

    pipe_exec_stage #(
        .SUPPORT_LOAD_BYPASS (SUPPORT_LOAD_BYPASS),
        .SUPPORT_MUL_BYPASS  (SUPPORT_MUL_BYPASS)
    ) u_exec (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .e1_i           (e1_w),
        .e1_result_i    (e1_result_i),
        .e2_result_i    (e2_result_i),
        .div_result_i   (div_result_i),
        .issue_stall_i  (issue_stall_i),
        .squash_e1_e2_i (squash_e1_e2_i),
        .e2_o           (e2_w),
        .result_e2_o    (result_e2_o),
        .stall_o        (stall_o),
        .squash_e1_e2_o (squash_e1_e2_o)
    );

    pipe_commit_stage u_commit
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .e2_i          (e2_w),
        .e2_result_i   (e2_result_i),
        .issue_stall_i (issue_stall_i),
        .squash_wb_i   (squash_wb_i),
        .commit_o      (commit_o)
    );

    //----------------------------------------------------------------------
    // hazard hints for the issue logic
    //----------------------------------------------------------------------
    assign load_e1_o   = e1_w.ctrl.load;
    assign store_e1_o  = e1_w.ctrl.store;
    assign mul_e1_o    = e1_w.ctrl.mul;
    assign branch_e1_o = e1_w.ctrl.branch;
    assign rd_e1_o     = e1_w.ctrl.rd_valid ? e1_w.opcode[RD_LSB +: 5] : '0;

    // E2 rd only counts once the op can actually move on
    assign e2_wr_w   = e2_w.valid & ~issue_stall_i & e2_w.ctrl.rd_valid & ~stall_o;
    assign load_e2_o = e2_w.ctrl.load;
    assign mul_e2_o  = e2_w.ctrl.mul;
    assign rd_e2_o   = e2_wr_w ? e2_w.opcode[RD_LSB +: 5] : '0;

endmodule

/* design/pipe_exec_stage.sv */
// E2 register, result select and exception resolution
// memory and multiply results arrive combinationally while E2 holds the op
`timescale 1ns/10ps

module pipe_exec_stage
#(
    parameter bit SUPPORT_LOAD_BYPASS = 1'b1,
    parameter bit SUPPORT_MUL_BYPASS  = 1'b1
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  pipe_ctrl_pkg::stage_t      e1_i,
    input  pipe_ctrl_pkg::e1_result_t  e1_result_i,
    input  pipe_ctrl_pkg::e2_result_t  e2_result_i,
    input  pipe_ctrl_pkg::div_result_t div_result_i,
    input  logic                      issue_stall_i,
    input  logic                      squash_e1_e2_i,
    output pipe_ctrl_pkg::stage_t      e2_o,
    output pipe_ctrl_pkg::word_t       result_e2_o,
    output logic                      stall_o,
    output logic                      squash_e1_e2_o
);
    import pipe_ctrl_pkg::*;

    logic        valid_q;
    ctrl_flags_t ctrl_q;
    excp_t       excp_q;
    word_t       pc_q;
    word_t       npc_q;
    word_t       opcode_q;
    word_t       ra_q;
    word_t       rb_q;
    word_t       result_q;
    logic        squash_q;

    logic        flush_w;
    logic        mem_e2_w;
    logic        valid_adv_w;
    excp_t       excp_w;
    word_t       result_w;

    assign flush_w     = squash_e1_e2_o | squash_e1_e2_i;
    assign mem_e2_w    = ctrl_q.load | ctrl_q.store;
    assign valid_adv_w = valid_q & ~issue_stall_i;

    //----------------------------------------------------------------------
    // E2 register
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
            excp_q  <= EXCP_NONE;
        end
        else if (!issue_stall_i)
        begin
            if (flush_w)
            begin
                valid_q <= 1'b0;
                ctrl_q  <= '0;
                excp_q  <= EXCP_NONE;
            end
            else
            begin
                valid_q <= e1_i.valid;
                ctrl_q  <= e1_i.ctrl;
                if (e1_i.ctrl.intr)
                    excp_q <= EXCP_INTERRUPT;
                else if (|e1_i.exception)
                begin
                    valid_q <= 1'b0;        // bad fetch never retires
                    excp_q  <= e1_i.exception;
                end
                else if (e1_i.valid)
                    excp_q <= e1_result_i.csr_exception;
                else
                    excp_q <= EXCP_NONE;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!issue_stall_i && !flush_w)
        begin
            pc_q     <= e1_i.pc;
            npc_q    <= e1_i.npc;
            opcode_q <= e1_i.opcode;
            ra_q     <= e1_i.operand_ra;
            rb_q     <= e1_i.operand_rb;
            if (e1_i.ctrl.div)
                result_q <= div_result_i.result;
            else if (e1_i.ctrl.csr)
                result_q <= e1_result_i.csr_value;
            else
                result_q <= e1_result_i.alu_result;
        end
    end

    // late result forwarding
    always_comb
    begin
        result_w = result_q;
        if (SUPPORT_LOAD_BYPASS && valid_adv_w && mem_e2_w)
            result_w = e2_result_i.mem_result;
        else if (SUPPORT_MUL_BYPASS && valid_adv_w && ctrl_q.mul)
            result_w = e2_result_i.mul_result;
    end

    // memory fault replaces whatever E2 carried
    assign excp_w = (valid_q && mem_e2_w && e2_result_i.mem_complete) ?
                    e2_result_i.mem_exception : excp_q;

    // divide waits in E1, memory access waits in E2
    assign stall_o = (e1_i.ctrl.div & ~div_result_i.complete)
                     | (mem_e2_w & ~e2_result_i.mem_complete);

    //----------------------------------------------------------------------
    // squash, held one extra unstalled cycle
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            squash_q <= 1'b0;
        else if (!issue_stall_i)
            squash_q <= |excp_w;
    end

    assign squash_e1_e2_o = (|excp_w) | squash_q;
    assign result_e2_o    = result_w;

    assign e2_o = '{valid: valid_q, ctrl: ctrl_q, pc: pc_q, npc: npc_q, opcode: opcode_q,
                    operand_ra: ra_q, operand_rb: rb_q, exception: excp_w,
                    result: result_q};

endmodule

/* design/pipe_issue_stage.sv */
// E1 capture, one instruction per cycle
// an issue is taken only when valid and accept are both high
`timescale 1ns/10ps

module pipe_issue_stage
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  pipe_ctrl_pkg::issue_req_t issue_req_i,
    input  logic                     issue_stall_i,
    input  logic                     squash_e1_e2_i, // external flush
    input  logic                     squash_local_i, // flush raised by E2
    output pipe_ctrl_pkg::stage_t    e1_o
);
    import pipe_ctrl_pkg::*;

    logic        valid_q;
    ctrl_flags_t ctrl_q;
    excp_t       excp_q;
    word_t       pc_q;
    word_t       npc_q;
    word_t       opcode_q;
    word_t       ra_q;
    word_t       rb_q;

    logic        accept_w;
    logic        misaligned_w;
    logic        intr_w;
    ctrl_flags_t ctrl_w;
    excp_t       excp_w;

    assign accept_w = issue_req_i.valid & issue_req_i.accept
                      & ~(squash_e1_e2_i | squash_local_i);
    assign intr_w   = issue_req_i.take_interrupt;

    // target must be word aligned
    assign misaligned_w = issue_req_i.branch_taken && (issue_req_i.branch_target[1:0] != 2'b00);

    //----------------------------------------------------------------------
    // classification
    //----------------------------------------------------------------------
    always_comb
    begin
        ctrl_w.alu      = ~(issue_req_i.lsu | issue_req_i.csr | issue_req_i.div
                            | issue_req_i.mul) & ~intr_w;
        ctrl_w.load     = issue_req_i.lsu & issue_req_i.rd_valid & ~intr_w;
        ctrl_w.store    = issue_req_i.lsu & ~issue_req_i.rd_valid & ~intr_w;
        ctrl_w.csr      = issue_req_i.csr & ~intr_w;
        ctrl_w.div      = issue_req_i.div & ~intr_w;
        ctrl_w.mul      = issue_req_i.mul & ~intr_w;
        ctrl_w.branch   = issue_req_i.branch & ~intr_w;
        ctrl_w.rd_valid = issue_req_i.rd_valid & ~intr_w;
        ctrl_w.intr     = intr_w;
        ctrl_w.complete = 1'b1;
    end

    // an exception from fetch/decode wins over the branch check
    assign excp_w = (|issue_req_i.exception) ? issue_req_i.exception :
                    misaligned_w             ? EXCP_MISALIGNED_FETCH : EXCP_NONE;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
            excp_q  <= EXCP_NONE;
        end
        else if (!issue_stall_i)
        begin
            valid_q <= accept_w;
            ctrl_q  <= accept_w ? ctrl_w : '0;   // bubble otherwise
            excp_q  <= accept_w ? excp_w : EXCP_NONE;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!issue_stall_i && accept_w)
        begin
            pc_q     <= issue_req_i.pc;
            npc_q    <= issue_req_i.branch_taken ? issue_req_i.branch_target
                                                 : issue_req_i.pc + PC_STEP;
            opcode_q <= issue_req_i.opcode;
            ra_q     <= issue_req_i.operand_ra;
            rb_q     <= issue_req_i.operand_rb;
        end
    end

    assign e1_o = '{valid: valid_q, ctrl: ctrl_q, pc: pc_q, npc: npc_q, opcode: opcode_q,
                    operand_ra: ra_q, operand_rb: rb_q, exception: excp_q, result: '0};

endmodule

/* pipe_ctrl.f */
design/pipe_ctrl_pkg.sv
design/pipe_issue_stage.sv
design/pipe_exec_stage.sv
design/pipe_commit_stage.sv
design/pipe_ctrl_top.sv
bench/pipe_ctrl_checker.sv
bench/pipe_ctrl_tb.sv
